/* source/geo_pixel_pkg.sv */
`default_nettype none

package geo_pixel_pkg;

    localparam int addr_w   = 20;                // graphics ram word address
    localparam int data_w   = 16;                // graphics ram word
    localparam int colour_w = 8;                 // immediate colour in a command
    localparam int cmd_w    = 40;                // full command word

    localparam logic [3:0] cmd_nop       = 4'd0;
    localparam logic [3:0] cmd_pxwri     = 4'd1;   // plain pixel write
    localparam logic [3:0] cmd_pxwri_m   = 4'd2;   // write, zero colour is transparent
    localparam logic [3:0] cmd_pxpaste   = 4'd3;   // write copy colour ^ colour
    localparam logic [3:0] cmd_pxpaste_m = 4'd4;   // paste with transparency
    localparam logic [3:0] cmd_pxcopy    = 4'd6;   // read pixel into copy colour
    localparam logic [3:0] cmd_setargb   = 4'd7;   // load copy colour directly

    // one command word, two decodings picked by the code field
    typedef union packed {
        struct packed {
            logic [3:0]          code;
            logic [colour_w-1:0] colour;
            logic [3:0]          bpp;     // bits per pixel minus one
            logic [3:0]          target;  // pixel index inside the word
            logic [addr_w-1:0]   addr;
        } pix;
        struct packed {
            logic [3:0]          code;
            logic [19:0]         pad;     // unused in this view
            logic [data_w-1:0]   rgb;     // new copy colour
        } argb;
    } pixel_cmd_u;

    // right-aligned field mask for a pixel width
    function automatic logic [data_w-1:0] pixel_mask(input logic [3:0] bpp);
        case (bpp)
            4'd0:                       return 16'h0001;
            4'd1, 4'd2:                 return 16'h0003;
            4'd3, 4'd4, 4'd5, 4'd6:     return 16'h000f;
            4'd15:                      return 16'hffff;
            default:                    return 16'h00ff;   // 7 and the unused 8..14
        endcase
    endfunction

    // pixel 0 sits at the msb end, so the field starts at 16 - (t+1)*width mod 16
    function automatic logic [3:0] pixel_shift(input logic [3:0] bpp, input logic [3:0] target);
        logic [7:0] span;
        span = ({4'd0, target} + 8'd1) * ({4'd0, bpp} + 8'd1);
        case (bpp)
            4'd0, 4'd1, 4'd3, 4'd7, 4'd15: return 4'd0 - span[3:0];
            default:                       return 4'd0;    // no such bitplane mode
        endcase
    endfunction

endpackage

`default_nettype wire

/* source/geo_pixel_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module geo_pixel_writer
    import geo_pixel_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              cmd_rdy,        // load strobe for cmd_in
    input  wire logic [cmd_w-1:0]  cmd_in,
    input  wire logic [data_w-1:0] rd_data_in,
    input  wire logic              rd_data_rdy_a,  // copy read done
    input  wire logic              rd_data_rdy_b,  // write read done
    input  wire logic              ram_mux_busy,
    output logic                   draw_busy,      // command buffer full
    output logic                   rd_req_a,
    output logic                   rd_req_b,
    output logic                   wr_ena,
    output logic [addr_w-1:0]      ram_addr,
    output logic [data_w-1:0]      ram_wr_data,
    output logic [data_w-1:0]      px_copy_colour
);

    pixel_cmd_u        head_cmd;
    logic              head_valid;
    logic              exec_cmd;          // pop and run the head command
    logic              write_cmd;
    logic              copy_cmd;
    logic              set_cmd;
    logic              paste;
    logic              mask_enable;
    logic              rd_wait_a;
    logic              rd_wait_b;
    logic              copy_colour_zero;
    logic [addr_w-1:0] wc_addr;           // address of the pending write

    pixel_cmd_fifo u_cmd_fifo (
        .clk       (clk),
        .reset     (reset),
        .shift_in  (cmd_rdy),
        .shift_out (exec_cmd),
        .data_in   (cmd_in),
        .not_empty (head_valid),
        .full      (draw_busy),
        .data_out  (head_cmd)
    );

    always_comb begin
        write_cmd   = 1'b0;
        copy_cmd    = 1'b0;
        set_cmd     = 1'b0;
        paste       = 1'b0;
        mask_enable = 1'b0;
        case (head_cmd.pix.code)
            cmd_pxwri:     write_cmd = 1'b1;
            cmd_pxwri_m: begin
                write_cmd   = 1'b1;
                mask_enable = 1'b1;
            end
            cmd_pxpaste: begin
                write_cmd = 1'b1;
                paste     = 1'b1;
            end
            cmd_pxpaste_m: begin
                write_cmd   = 1'b1;
                paste       = 1'b1;
                mask_enable = 1'b1;
            end
            cmd_pxcopy:    copy_cmd = 1'b1;
            cmd_setargb:   set_cmd  = 1'b1;
            cmd_nop:       ;                               // popped, nothing to do
            default:       ;                               // unknown codes act as nop
        endcase
    end

    // one command in flight, and never issue over a pending write strobe
    assign exec_cmd = head_valid && !rd_wait_a && !rd_wait_b && !ram_mux_busy && !wr_ena;
    assign ram_addr = wr_ena ? wc_addr : head_cmd.pix.addr;

    pixel_write_cache u_write_cache (
        .clk              (clk),
        .reset            (reset),
        .write_go         (exec_cmd && write_cmd),
        .paste            (paste),
        .mask_enable      (mask_enable),
        .cmd              (head_cmd),
        .rd_data_in       (rd_data_in),
        .copy_colour      (px_copy_colour),
        .copy_colour_zero (copy_colour_zero),
        .rd_data_rdy_b    (rd_data_rdy_b),
        .wr_hit           (),
        .rd_wait_b        (rd_wait_b),
        .rd_req_b         (rd_req_b),
        .wr_ena           (wr_ena),
        .wc_addr          (wc_addr),
        .ram_wr_data      (ram_wr_data)
    );

    pixel_copy_cache u_copy_cache (
        .clk              (clk),
        .reset            (reset),
        .copy_go          (exec_cmd && copy_cmd),
        .set_colour       (exec_cmd && set_cmd),
        .cmd              (head_cmd),
        .rd_data_in       (rd_data_in),
        .rd_data_rdy_a    (rd_data_rdy_a),
        .wr_ena           (wr_ena),
        .wc_addr          (wc_addr),
        .ram_wr_data      (ram_wr_data),
        .rd_hit           (),
        .rd_wait_a        (rd_wait_a),
        .rd_req_a         (rd_req_a),
        .px_copy_colour   (px_copy_colour),
        .copy_colour_zero (copy_colour_zero)
    );

endmodule

`default_nettype wire

/* source/pixel_cmd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_cmd_fifo
    import geo_pixel_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       shift_in,    // load strobe from the command source
    input  wire logic       shift_out,   // pop strobe from the writer
    input  wire pixel_cmd_u data_in,
    output logic            not_empty,
    output logic            full,
    output pixel_cmd_u      data_out     // head word, fall-through
);

    logic [1:0] count;    // 0, 1 or 2 words held
    logic [1:0] tail;     // slot taking a pushed word
    logic       do_push;
    logic       do_pop;
    pixel_cmd_u word0;    // head
    pixel_cmd_u word1;

    assign not_empty = (count != 2'd0);
    assign full      = (count == 2'd2);
    assign data_out  = word0;

    assign do_pop  = shift_out && not_empty;            // ignore pops on empty
    assign do_push = shift_in && (!full || do_pop);     // ignore pushes on full
    assign tail    = count - {1'b0, do_pop};            // free slot after the pop

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= 2'd0;
        end else if (do_push && !do_pop) begin
            count <= count + 2'd1;
        end else if (do_pop && !do_push) begin
            count <= count - 2'd1;
        end                                             // push with pop keeps the count
    end

    always_ff @(posedge clk) begin
        if (do_pop) begin
            word0 <= word1;                             // second word moves to head
        end
        if (do_push) begin
            if (tail == 2'd0) begin
                word0 <= data_in;                       // overrides the shift above
            end else begin
                word1 <= data_in;
            end
        end
    end

endmodule

`default_nettype wire

/* source/pixel_copy_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_copy_cache
    import geo_pixel_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              copy_go,        // issue of a copy
    input  wire logic              set_colour,     // issue of a set copy colour
    input  wire pixel_cmd_u        cmd,
    input  wire logic [data_w-1:0] rd_data_in,
    input  wire logic              rd_data_rdy_a,
    input  wire logic              wr_ena,         // write snoop
    input  wire logic [addr_w-1:0] wc_addr,
    input  wire logic [data_w-1:0] ram_wr_data,
    output logic                   rd_hit,
    output logic                   rd_wait_a,
    output logic                   rd_req_a,
    output logic [data_w-1:0]      px_copy_colour,
    output logic                   copy_colour_zero
);

    logic                rc_valid;
    logic [addr_w-1:0]   rc_addr;
    logic [data_w-1:0]   rcd;              // last read word
    logic [colour_w-1:0] rc_colour;
    logic [3:0]          rc_bpp;
    logic [3:0]          rc_target;

    logic [data_w-1:0]   op_word;
    logic [3:0]          op_bpp;
    logic [3:0]          op_target;
    logic [colour_w-1:0] op_colour;
    logic [data_w-1:0]   copy_val;
    logic                miss_go;
    logic                miss_done;

    assign rd_hit    = rc_valid && (cmd.pix.addr == rc_addr);
    assign miss_go   = copy_go && !rd_hit;
    assign miss_done = rd_data_rdy_a && rd_wait_a;
    assign rd_req_a  = miss_go;

    always_comb begin
        op_word   = rd_wait_a ? rd_data_in : rcd;
        op_bpp    = rd_wait_a ? rc_bpp     : cmd.pix.bpp;
        op_target = rd_wait_a ? rc_target  : cmd.pix.target;
        op_colour = rd_wait_a ? rc_colour  : cmd.pix.colour;
        // pull the target pixel down to bit 0, then xor in the colour
        copy_val  = ((op_word >> pixel_shift(op_bpp, op_target)) & pixel_mask(op_bpp))
                    ^ data_w'(op_colour);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rc_valid         <= 1'b0;
            rd_wait_a        <= 1'b0;
            px_copy_colour   <= '0;
            copy_colour_zero <= 1'b1;                     // matches the cleared colour
        end else if (set_colour) begin
            px_copy_colour   <= cmd.argb.rgb;
            copy_colour_zero <= 1'b0;                     // a set colour is never transparent
            rc_valid         <= 1'b0;
        end else if (miss_done) begin
            rd_wait_a        <= 1'b0;
            rc_valid         <= 1'b1;
            px_copy_colour   <= copy_val;
            copy_colour_zero <= (copy_val == '0);
        end else if (miss_go) begin
            rd_wait_a        <= 1'b1;
            rc_valid         <= 1'b0;
        end else if (copy_go) begin                       // hit, answer from rcd
            px_copy_colour   <= copy_val;
            copy_colour_zero <= (copy_val == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (miss_go) begin
            rc_addr   <= cmd.pix.addr;
            rc_colour <= cmd.pix.colour;
            rc_bpp    <= cmd.pix.bpp;
            rc_target <= cmd.pix.target;
        end
        if (miss_done) begin
            rcd <= rd_data_in;
        end else if (wr_ena && rc_valid && (wc_addr == rc_addr)) begin
            rcd <= ram_wr_data;                           // keep the copy in step with ram
        end
    end

endmodule

`default_nettype wire

/* source/pixel_write_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_write_cache
    import geo_pixel_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              write_go,          // issue of any write class command
    input  wire logic              paste,             // colour comes from the copy register
    input  wire logic              mask_enable,       // zero colour is transparent
    input  wire pixel_cmd_u        cmd,               // head command
    input  wire logic [data_w-1:0] rd_data_in,
    input  wire logic [data_w-1:0] copy_colour,
    input  wire logic              copy_colour_zero,
    input  wire logic              rd_data_rdy_b,
    output logic                   wr_hit,
    output logic                   rd_wait_b,
    output logic                   rd_req_b,
    output logic                   wr_ena,
    output logic [addr_w-1:0]      wc_addr,
    output logic [data_w-1:0]      ram_wr_data
);

    logic                wc_valid;
    logic [data_w-1:0]   wcd;              // last written word
    logic [colour_w-1:0] wc_colour;        // fields latched on a miss
    logic [3:0]          wc_bpp;
    logic [3:0]          wc_target;
    logic                wc_paste;
    logic                wc_mask;

    logic [data_w-1:0]   op_word;          // word being merged into
    logic [colour_w-1:0] op_colour;
    logic [3:0]          op_bpp;
    logic [3:0]          op_target;
    logic                op_paste;
    logic                op_mask;
    logic [data_w-1:0]   field_mask;
    logic [3:0]          shift;
    logic [data_w-1:0]   colour_sel;
    logic [data_w-1:0]   merged;
    logic                transparent;
    logic [data_w-1:0]   new_word;
    logic                miss_go;          // write issued, needs a ram read
    logic                miss_done;        // read data for that write is back
    logic                load_word;

    assign wr_hit    = wc_valid && (cmd.pix.addr == wc_addr);
    assign miss_go   = write_go && !wr_hit;
    assign miss_done = rd_data_rdy_b && rd_wait_b;
    assign load_word = miss_done || (write_go && wr_hit);
    assign rd_req_b  = miss_go;                           // one pulse per miss

    // operands come from the latched miss or straight from the head command
    always_comb begin
        op_word   = rd_wait_b ? rd_data_in : wcd;
        op_colour = rd_wait_b ? wc_colour  : cmd.pix.colour;
        op_bpp    = rd_wait_b ? wc_bpp     : cmd.pix.bpp;
        op_target = rd_wait_b ? wc_target  : cmd.pix.target;
        op_paste  = rd_wait_b ? wc_paste   : paste;
        op_mask   = rd_wait_b ? wc_mask    : mask_enable;

        field_mask = pixel_mask(op_bpp);
        shift      = pixel_shift(op_bpp, op_target);
        colour_sel = op_paste ? (copy_colour ^ data_w'(op_colour)) : data_w'(op_colour);
        colour_sel = colour_sel & field_mask;             // keep paste inside its pixel
        merged     = (op_word & ~(field_mask << shift)) | (colour_sel << shift);

        transparent = op_mask && (op_paste ? copy_colour_zero : (op_colour == '0));
        new_word    = transparent ? op_word : merged;     // transparent writes the old word back
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wc_valid  <= 1'b0;
            rd_wait_b <= 1'b0;
            wr_ena    <= 1'b0;
        end else begin
            wr_ena <= load_word;                          // one cycle strobe
            if (miss_done) begin
                rd_wait_b <= 1'b0;
                wc_valid  <= 1'b1;                        // cache now holds the merged word
            end else if (miss_go) begin
                rd_wait_b <= 1'b1;                        // stall until the read returns
                wc_valid  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss_go) begin
            wc_addr   <= cmd.pix.addr;
            wc_colour <= cmd.pix.colour;
            wc_bpp    <= cmd.pix.bpp;
            wc_target <= cmd.pix.target;
            wc_paste  <= paste;
            wc_mask   <= mask_enable;
        end
        if (load_word) begin
            wcd         <= new_word;
            ram_wr_data <= new_word;
        end
    end

endmodule

`default_nettype wire

/* tests/geo_pixel_writer_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module geo_pixel_writer_properties (
    input wire logic clk,
    input wire logic reset,
    input wire logic wr_ena,
    input wire logic rd_req_a,
    input wire logic rd_req_b,
    input wire logic ram_mux_busy
);

    int failures = 0;   // read by the testbench when the run ends

    // write strobe is a single cycle pulse
    wr_ena_pulse: assert property (@(posedge clk) disable iff (reset) wr_ena |=> !wr_ena)
        else begin
            failures = failures + 1;
            $error("wr_ena stayed high for two cycles");
        end

    // only one read channel asks at a time
    req_one_hot: assert property (@(posedge clk) disable iff (reset) !(rd_req_a && rd_req_b))
        else begin
            failures = failures + 1;
            $error("rd_req_a and rd_req_b high together");
        end

    req_not_busy: assert property (@(posedge clk) disable iff (reset)
                                   ram_mux_busy |-> !(rd_req_a || rd_req_b))
        else begin
            failures = failures + 1;
            $error("read request while ram_mux_busy is high");
        end

endmodule

bind geo_pixel_writer geo_pixel_writer_properties u_props (
    .clk          (clk),
    .reset        (reset),
    .wr_ena       (wr_ena),
    .rd_req_a     (rd_req_a),
    .rd_req_b     (rd_req_b),
    .ram_mux_busy (ram_mux_busy)
);

`default_nettype wire

/* tests/geo_pixel_writer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module geo_pixel_writer_tb
    import geo_pixel_pkg::*;
();

    localparam logic [addr_w-1:0] win_base   = 20'h52a30;   // 16 word window, low nibble clear
    localparam int                wait_limit = 500;         // cycles before a wait gives up

    logic              clk;
    logic              reset;
    logic              cmd_rdy;
    logic [cmd_w-1:0]  cmd_in;
    logic [data_w-1:0] rd_data_in;
    logic              rd_data_rdy_a;
    logic              rd_data_rdy_b;
    logic              ram_mux_busy;
    logic              draw_busy;
    logic              rd_req_a;
    logic              rd_req_b;
    logic              wr_ena;
    logic [addr_w-1:0] ram_addr;
    logic [data_w-1:0] ram_wr_data;
    logic [data_w-1:0] px_copy_colour;

    logic [data_w-1:0] ram_mem [16];     // words held by the ram model
    logic [data_w-1:0] ref_mem [16];     // reference array, updated in command order
    logic [data_w-1:0] model_copy;       // expected copy colour
    logic              model_copy_zero;  // expected transparency of a masked paste
    logic [addr_w-1:0] exp_addr_q [$];   // writes the dut still owes
    logic [data_w-1:0] exp_data_q [$];
    logic              busy_seen;
    int unsigned       seed_ret;
    pixel_cmd_u        cmd;
    logic              is_copy;

    geo_pixel_writer DUT (
        .clk            (clk),
        .reset          (reset),
        .cmd_rdy        (cmd_rdy),
        .cmd_in         (cmd_in),
        .rd_data_in     (rd_data_in),
        .rd_data_rdy_a  (rd_data_rdy_a),
        .rd_data_rdy_b  (rd_data_rdy_b),
        .ram_mux_busy   (ram_mux_busy),
        .draw_busy      (draw_busy),
        .rd_req_a       (rd_req_a),
        .rd_req_b       (rd_req_b),
        .wr_ena         (wr_ena),
        .ram_addr       (ram_addr),
        .ram_wr_data    (ram_wr_data),
        .px_copy_colour (px_copy_colour)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                    // 8 ns period
    end

    function automatic logic [data_w-1:0] width_mask(input int width);
        return data_w'((32'd1 << width) - 32'd1);
    endfunction

    // pixel 0 is the msb end, so target t starts at 16 - (t+1)*width
    function automatic int field_pos(input int width, input int t);
        return (16 - (t + 1) * width) % 16;
    endfunction

    function automatic logic [data_w-1:0] fill_word(input logic [addr_w-1:0] a);
        return a[15:0] ^ {4{a[19:16]}} ^ 16'hc3a5;
    endfunction

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t: %s", $time, what);
        stop_run();
    endtask

    task automatic check_word(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input logic [addr_w-1:0] got,
                              input logic [addr_w-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic pixel_cmd_u make_cmd();
        pixel_cmd_u  c;
        logic [3:0]  code;
        int unsigned r;
        int          width;
        c = '0;                                   // fields set below
        case ($urandom % 16)
            0, 1, 2: code = cmd_pxwri;
            3, 4:    code = cmd_pxwri_m;
            5, 6:    code = cmd_pxpaste;
            7, 8:    code = cmd_pxpaste_m;
            9, 10, 11: code = cmd_pxcopy;
            12:      code = cmd_setargb;
            13:      code = cmd_nop;
            14:      code = 4'd5;                  // unused code, consumed as nop
            default: code = 4'd8 + 4'($urandom % 8);
        endcase
        case ($urandom % 5)
            0:       c.pix.bpp = 4'd0;
            1:       c.pix.bpp = 4'd1;
            2:       c.pix.bpp = 4'd3;
            3:       c.pix.bpp = 4'd7;
            default: c.pix.bpp = 4'd15;
        endcase
        width = int'(c.pix.bpp) + 1;
        c.pix.target = 4'($urandom % (16 / width));
        r = $urandom;
        c.pix.colour = ($urandom % 4 == 0) ? '0 : r[colour_w-1:0];   // zero now and then
        c.pix.addr = win_base + addr_w'($urandom % 16);
        if (code == cmd_setargb) begin
            r = $urandom;
            c.argb.pad = r[19:0];
            r = $urandom;
            c.argb.rgb = ($urandom % 4 == 0) ? '0 : r[data_w-1:0];
        end
        c.pix.code = code;
        return c;
    endfunction

    // executes one command on the reference array in issue order
    task automatic apply_model(input pixel_cmd_u c, output logic copy_done);
        logic [data_w-1:0] mask;
        logic [data_w-1:0] colour;
        logic [data_w-1:0] old_word;
        logic [data_w-1:0] new_word;
        logic              is_paste;
        logic              is_mask;
        logic              transparent;
        int                width;
        int                pos;
        int                idx;
        copy_done = 1'b0;
        width = int'(c.pix.bpp) + 1;
        mask  = width_mask(width);
        pos   = field_pos(width, int'(c.pix.target));
        idx   = int'(c.pix.addr[3:0]);
        case (c.pix.code)
            cmd_pxwri, cmd_pxwri_m, cmd_pxpaste, cmd_pxpaste_m: begin
                is_paste = (c.pix.code == cmd_pxpaste) || (c.pix.code == cmd_pxpaste_m);
                is_mask  = (c.pix.code == cmd_pxwri_m) || (c.pix.code == cmd_pxpaste_m);
                colour   = {8'd0, c.pix.colour};
                if (is_paste) begin
                    colour = model_copy ^ colour;
                end
                transparent = is_mask && (is_paste ? model_copy_zero : (c.pix.colour == '0));
                old_word = ref_mem[idx];
                new_word = (old_word & ~(mask << pos)) | ((colour & mask) << pos);
                if (transparent) begin
                    new_word = old_word;            // old word is written back
                end
                ref_mem[idx] = new_word;
                exp_addr_q.push_back(c.pix.addr);
                exp_data_q.push_back(new_word);
            end
            cmd_pxcopy: begin
                model_copy      = ((ref_mem[idx] >> pos) & mask) ^ {8'd0, c.pix.colour};
                model_copy_zero = (model_copy == '0);
                copy_done       = 1'b1;
            end
            cmd_setargb: begin
                model_copy      = c.argb.rgb;
                model_copy_zero = 1'b0;             // never transparent after a set
            end
            default: ;                              // nop and unknown codes
        endcase
    endtask

    task automatic load_cmd(input pixel_cmd_u c);
        int waited;
        waited = 0;
        @(negedge clk);
        while (draw_busy) begin
            if (waited == wait_limit) begin
                report_failure("command buffer stayed full, draw_busy never dropped");
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
        cmd_rdy <= 1'b1;
        cmd_in  <= c;
        @(posedge clk);
        cmd_rdy <= 1'b0;                            // one cycle load strobe
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (DUT.head_valid || DUT.rd_wait_a || DUT.rd_wait_b || wr_ena) begin
            if (waited == wait_limit) begin
                report_failure("writer did not drain its commands in time");
            end
            waited++;
            @(negedge clk);
        end
    endtask

    // answers reads after 1 to 6 cycles, commits writes and checks them
    task automatic ram_model();
        logic              pending;
        logic              pend_b;
        logic [addr_w-1:0] pend_addr;
        int                delay;
        pending = 1'b0;
        forever begin
            @(negedge clk);
            if (draw_busy) begin
                busy_seen = 1'b1;
            end
            if (wr_ena) begin
                if (exp_addr_q.size() == 0) begin
                    report_failure("write strobe with no write left in the reference model");
                end
                check_addr("ram_addr", ram_addr, exp_addr_q.pop_front());
                check_word("ram_wr_data", ram_wr_data, exp_data_q.pop_front());
                ram_mem[ram_addr[3:0]] = ram_wr_data;
            end
            if (rd_req_a || rd_req_b) begin
                if (pending) begin
                    report_failure("read request while another read was outstanding");
                end
                pending   = 1'b1;
                pend_b    = rd_req_b;
                pend_addr = ram_addr;
                delay     = int'($urandom_range(5, 0));
            end
            @(posedge clk);
            rd_data_rdy_a <= 1'b0;
            rd_data_rdy_b <= 1'b0;
            ram_mux_busy  <= ($urandom % 5 == 0);    // busy about a fifth of the time
            if (pending) begin
                if (delay == 0) begin
                    rd_data_in <= ram_mem[pend_addr[3:0]];
                    if (pend_b) begin
                        rd_data_rdy_b <= 1'b1;
                    end else begin
                        rd_data_rdy_a <= 1'b1;
                    end
                    pending = 1'b0;
                end else begin
                    delay--;
                end
            end
        end
    endtask

    initial begin
        seed_ret        = $urandom(32'h8cdab30c);
        reset           = 1'b1;
        cmd_rdy         = 1'b0;
        cmd_in          = '0;
        rd_data_in      = '0;
        rd_data_rdy_a   = 1'b0;
        rd_data_rdy_b   = 1'b0;
        ram_mux_busy    = 1'b0;
        model_copy      = '0;
        model_copy_zero = 1'b1;                     // cleared copy colour is zero
        busy_seen       = 1'b0;
        for (int i = 0; i < 16; i++) begin
            ram_mem[i] = fill_word(win_base + addr_w'(i));
            ref_mem[i] = fill_word(win_base + addr_w'(i));
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_level("wr_ena", wr_ena, 1'b0);
        check_level("rd_req_a", rd_req_a, 1'b0);
        check_level("rd_req_b", rd_req_b, 1'b0);
        check_level("draw_busy", draw_busy, 1'b0);
        fork
            ram_model();
        join_none
        for (int n = 0; n < 2000; n++) begin
            cmd = make_cmd();
            apply_model(cmd, is_copy);
            load_cmd(cmd);
            if (is_copy) begin
                wait_idle();
                check_word("px_copy_colour", px_copy_colour, model_copy);
            end else if ($urandom % 8 == 0) begin
                repeat (1 + $urandom % 4) @(posedge clk);   // short pause in the stream
            end
        end
        wait_idle();
        if (exp_addr_q.size() != 0) begin
            report_failure("writer finished with writes still missing");
        end
        for (int i = 0; i < 16; i++) begin
            check_word($sformatf("ram word %0d", i), ram_mem[i], ref_mem[i]);
        end
        check_word("px_copy_colour", px_copy_colour, model_copy);
        if (!busy_seen) begin
            report_failure("draw_busy never went high during the command stream");
        end
        if (DUT.u_props.failures != 0) begin
            report_failure("a bound assertion on the top level strobes failed");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
source/geo_pixel_pkg.sv
source/pixel_cmd_fifo.sv
source/pixel_write_cache.sv
source/pixel_copy_cache.sv
source/geo_pixel_writer.sv
tests/geo_pixel_writer_properties.sv
tests/geo_pixel_writer_tb.sv
